/* audio_pkg.sv */
package audio_pkg;

    // Width of a host duty value and of a stream sample
    localparam int sample_w = 12;

    typedef logic [sample_w-1:0] duty_t;

    // One PWM period covers every duty count
    localparam int pwm_period = 4096;

    // Stream sample buffer
    localparam int fifo_depth = 4;

    // Occupancy needs one bit more than the address to hold a full FIFO
    typedef logic [$clog2(fifo_depth):0] fifo_count_t;

    // Command to the PWM generator, taken once per period
    typedef struct packed {
        duty_t duty;
        logic  mute;
    } pwm_cmd_t;

    // Source selection of the DAC controller
    // DAC_REG takes host duty values over req/ack
    // DAC_STREAM pops one FIFO sample per period
    // DAC_STARVED found the FIFO empty and holds the last duty
    typedef enum logic [1:0] {
        DAC_REG,
        DAC_STREAM,
        DAC_STARVED
    } dac_state_t;

endpackage

/* audio_tb.sv */
module audio_tb import board_pkg::*, audio_pkg::*; ();

    timeunit 1ns;
    timeprecision 10ps;

    localparam int seed = 65;
    localparam int n_reg = 8;
    localparam int n_stream = 10;
    localparam int clk_ns = 4;
    // Longest debounce delay of a press, with some slack
    localparam int hold_cycles = (pulse_count_max + 1) * sample_count_max + 8;
    localparam int total_periods = n_reg + n_stream + 24;

    logic        cpu_clk_g = 1'b0;
    logic        rst;
    button_vec_t buttons;
    duty_t       duty_cycle;
    logic        req;
    duty_t       wave;
    logic        wave_valid;
    logic        ack;
    logic        wave_full;
    logic        pwm;
    led_status_t leds;

    // Reference model state
    longint cyc = 0;
    longint origin;
    bit     model_on = 1'b0;
    duty_t  fifo_q[$];
    bit     stream_mode;
    bit     model_mute;
    bit     model_underrun;
    duty_t  cur_duty;
    bit     cur_mute;
    bit     ack_due;
    bit     pop_due;
    int     high_cnt;

    audio_top dut (
        .cpu_clk_g (cpu_clk_g),
        .rst       (rst),
        .buttons   (buttons),
        .duty_cycle(duty_cycle),
        .req       (req),
        .wave      (wave),
        .wave_valid(wave_valid),
        .ack       (ack),
        .wave_full (wave_full),
        .pwm       (pwm),
        .leds      (leds)
    );

    always #(clk_ns / 2) cpu_clk_g = ~cpu_clk_g;

    always @(posedge cpu_clk_g) cyc <= cyc + 1;

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input int expected, input int actual, input string what);
        if (expected != actual) begin
            $display("ERR %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
            fail_run();
        end
    endtask

    // Position inside the PWM period, counted from the last reset release
    function automatic int period_count();
        return int'((cyc - origin) % pwm_period);
    endfunction

    task automatic wait_count(input int c);
        @(negedge cpu_clk_g);
        while (period_count() != c) @(negedge cpu_clk_g);
    endtask

    task automatic skip_periods(input int n);
        repeat (n) wait_count(16);
    endtask

    task automatic wait_ack(input bit expect_low, output longint at_cyc);
        int n;
        n = 0;
        @(negedge cpu_clk_g);
        while (!ack) begin
            if (expect_low) check_val(0, int'(pwm), "pwm in first period after reset");
            n++;
            if (n > 2 * pwm_period) begin
                $display("Timed out at %0t waiting for ack from the DUT", $time);
                fail_run();
            end
            @(negedge cpu_clk_g);
        end
        at_cyc = cyc;
    endtask

    task automatic restart_model(input longint org, input duty_t duty);
        origin = org;
        fifo_q.delete();
        stream_mode = 1'b0;
        model_mute = 1'b0;
        model_underrun = 1'b0;
        cur_mute = 1'b0;
        cur_duty = duty;
        ack_due = 1'b0;
        pop_due = 1'b0;
        high_cnt = 0;
        model_on = 1'b1;
    endtask

    // Press early in a period so the effect lands well before period_end
    task automatic press_button(input int idx);
        wait_count(16);
        @(posedge cpu_clk_g);
        #1;
        buttons[idx] = 1'b1;
        repeat (hold_cycles) @(posedge cpu_clk_g);
        #1;
        buttons[idx] = 1'b0;
        case (idx)
            1: begin
                stream_mode = !stream_mode;
                check_val(int'(stream_mode), int'(leds.source_stream), "source_stream led");
            end
            2: begin
                model_mute = !model_mute;
                check_val(int'(model_mute), int'(leds.muted), "muted led");
            end
            default: begin
                model_underrun = 1'b0;
                check_val(0, int'(leds.underrun), "underrun led after clear");
            end
        endcase
    endtask

    // Host side writer, honours wave_full
    task automatic write_samples(input int n);
        int left;
        left = n;
        while (left > 0) begin
            @(posedge cpu_clk_g);
            #1;
            wave_valid = !wave_full;
            if (!wave_full) begin
                wave = duty_t'($urandom_range(pwm_period - 1, 0));
                left--;
            end
        end
        @(posedge cpu_clk_g);
        #1;
        wave_valid = 1'b0;
    endtask

    // Cycle model of FIFO, duty source and req/ack, sampled at the falling edge
    always @(negedge cpu_clk_g) begin : model_check
        int c;
        bit wr_ok;
        if (model_on) begin
            c = period_count();
            check_val(int'(c == 0 && ack_due), int'(ack), "ack timing");
            check_val(int'(fifo_q.size() == fifo_depth), int'(wave_full), "wave_full");
            check_val(int'(fifo_q.size() == 0), int'(leds.fifo_empty), "fifo_empty led");
            high_cnt += int'(pwm);
            wr_ok = wave_valid && (fifo_q.size() < fifo_depth);
            if (c == pwm_period - 1) begin
                check_val(cur_mute ? 0 : int'(cur_duty), high_cnt, "pwm high count");
                high_cnt = 0;
                cur_mute = model_mute;
                if (!stream_mode) begin
                    if (req) begin
                        cur_duty = duty_cycle;
                        ack_due = 1'b1;
                    end
                end else if (fifo_q.size() != 0) begin
                    cur_duty = fifo_q[0];
                    pop_due = 1'b1;
                end else begin
                    model_underrun = 1'b1;
                end
            end
            // The pop lands one cycle after the boundary
            if (c == 0) begin
                // Presses only happen mid period, so the flags are settled here
                check_val(int'({stream_mode, model_mute, model_underrun}),
                          int'({leds.source_stream, leds.muted, leds.underrun}),
                          "led flags at period start");
                ack_due = 1'b0;
                if (pop_due) void'(fifo_q.pop_front());
                pop_due = 1'b0;
            end
            if (wr_ok) fifo_q.push_back(wave);
        end
    end

    initial begin
        #(total_periods * pwm_period * clk_ns + 1000);
        $display("Simulation timed out before all tests finished");
        fail_run();
    end

    initial begin
        longint ack_cyc;
        longint rel_cyc;
        duty_t  d;
        bit     in_window;
        void'($urandom(seed));
        rst = 1'b1;
        buttons = '0;
        duty_cycle = '0;
        req = 1'b0;
        wave = '0;
        wave_valid = 1'b0;

        repeat (3) @(posedge cpu_clk_g);
        #1;
        rst = 1'b0;
        check_val(4'b0001, int'(leds), "leds after reset");
        check_val(0, int'(ack), "ack after reset");
        check_val(0, int'(pwm), "pwm after reset");
        restart_model(cyc, '0);
        skip_periods(2);

        // Host register path
        for (int i = 0; i < n_reg; i++) begin
            wait_count(100);
            @(posedge cpu_clk_g);
            #1;
            duty_cycle = duty_t'($urandom_range(pwm_period - 1, 0));
            req = 1'b1;
            wait_ack(1'b0, ack_cyc);
            @(posedge cpu_clk_g);
            #1;
            req = 1'b0;
        end

        // Stream path, then drain into underrun
        fork
            write_samples(n_stream);
            press_button(1);
        join
        skip_periods(fifo_depth + 2);
        check_val(1, int'(leds.underrun), "underrun after FIFO drained");
        press_button(3);
        press_button(1);

        press_button(2);
        skip_periods(3);
        press_button(2);
        skip_periods(2);

        // Reset button held through debounce
        wait_count(16);
        @(posedge cpu_clk_g);
        #1;
        model_on = 1'b0;
        buttons[0] = 1'b1;
        repeat (hold_cycles) @(posedge cpu_clk_g);
        #1;
        check_val(4'b0001, int'(leds), "leds during button reset");
        check_val(0, int'(ack), "ack during button reset");
        check_val(0, int'(pwm), "pwm during button reset");
        buttons[0] = 1'b0;
        rel_cyc = cyc;
        d = duty_t'($urandom_range(pwm_period - 1, 1));
        duty_cycle = d;
        req = 1'b1;
        wait_ack(1'b1, ack_cyc);
        // Release takes up to one sample interval plus sync delay
        in_window = (ack_cyc >= rel_cyc + pwm_period) &&
                    (ack_cyc <= rel_cyc + pwm_period + sample_count_max + 3);
        check_val(1, int'(in_window), "first ack after button reset release");
        @(posedge cpu_clk_g);
        #1;
        req = 1'b0;
        check_val(4'b0001, int'(leds), "leds after button reset");
        restart_model(ack_cyc, d);
        skip_periods(2);

        $display("All tests passed");
        $finish;
    end

endmodule

/* audio_top.f */
board_pkg.sv
audio_pkg.sv
sample_timer.sv
button_parser.sv
wave_fifo.sv
pwm_gen.sv
dac_ctrl.sv
audio_top.sv
audio_tb.sv

/* audio_top.sv */
module audio_top import board_pkg::*, audio_pkg::*; (
    input  logic        cpu_clk_g,
    input  logic        rst,
    input  button_vec_t buttons,
    input  duty_t       duty_cycle,
    input  logic        req,
    input  duty_t       wave,
    input  logic        wave_valid,
    output logic        ack,
    output logic        wave_full,
    output logic        pwm,
    output led_status_t leds
);

    logic        sys_rst;
    button_vec_t presses;
    logic        empty;
    duty_t       rd_data;
    logic        rd_en;
    logic        period_end;
    pwm_cmd_t    cmd;

    // Reset comes from the rst input or the debounced reset button
    button_parser u_button_parser (
        .cpu_clk_g(cpu_clk_g),
        .rst      (rst),
        .buttons  (buttons),
        .sys_rst  (sys_rst),
        .presses  (presses)
    );

    wave_fifo u_wave_fifo (
        .cpu_clk_g(cpu_clk_g),
        .sys_rst  (sys_rst),
        .wr_en    (wave_valid),
        .wr_data  (wave),
        .full     (wave_full),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (empty)
    );

    dac_ctrl u_dac_ctrl (
        .cpu_clk_g (cpu_clk_g),
        .sys_rst   (sys_rst),
        .presses   (presses),
        .duty_cycle(duty_cycle),
        .req       (req),
        .ack       (ack),
        .empty     (empty),
        .rd_data   (rd_data),
        .rd_en     (rd_en),
        .period_end(period_end),
        .cmd       (cmd),
        .leds      (leds)
    );

    pwm_gen u_pwm_gen (
        .cpu_clk_g (cpu_clk_g),
        .sys_rst   (sys_rst),
        .cmd       (cmd),
        .period_end(period_end),
        .pwm       (pwm)
    );

endmodule

/* board_pkg.sv */
package board_pkg;

    // Push buttons on the board
    // Button 0 is reset, 1 selects the source, 2 mutes, 3 clears underrun
    localparam int num_buttons = 4;

    // Debounce timing, kept short so the board and the simulation share it
    // Cycles between two samples of the synchronized button level
    localparam int sample_count_max = 8;

    // Consecutive high samples before a button counts as pressed
    localparam int pulse_count_max = 4;

    typedef logic [num_buttons-1:0] button_vec_t;

    // Status shown on the board LEDs, MSB first
    typedef struct packed {
        logic source_stream;
        logic muted;
        logic underrun;
        logic fifo_empty;
    } led_status_t;

endpackage

/* button_parser.sv */
module button_parser import board_pkg::*; (
    input  logic        cpu_clk_g,
    input  logic        rst,
    input  button_vec_t buttons,
    output logic        sys_rst,
    output button_vec_t presses
);

    typedef logic [$clog2(pulse_count_max+1)-1:0] press_cnt_t;

    logic        sample_tick;
    button_vec_t sync_1;
    button_vec_t sync_2;
    button_vec_t clean;
    button_vec_t clean_q;
    press_cnt_t  press_cnt [num_buttons];

    sample_timer u_sample_timer (
        .cpu_clk_g  (cpu_clk_g),
        .rst        (rst),
        .sample_tick(sample_tick)
    );

    // Two flop synchronizer, the buttons are asynchronous to the board clock
    always_ff @(posedge cpu_clk_g) begin
        sync_1 <= buttons;
        sync_2 <= sync_1;
    end

    // Saturating count of high samples per button
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            for (int i = 0; i < num_buttons; i++) begin
                press_cnt[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < num_buttons; i++) begin
                if (!sync_2[i]) begin
                    press_cnt[i] <= '0;
                end else if (press_cnt[i] != press_cnt_t'(pulse_count_max)) begin
                    press_cnt[i] <= press_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_buttons; i++) begin
            clean[i] = (press_cnt[i] == press_cnt_t'(pulse_count_max));
        end
    end

    // Held reset button keeps the whole design in reset
    assign sys_rst = rst | clean[0];

    // One cycle pulse on each rising edge, button 0 gives no press
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            clean_q <= '0;
            presses <= '0;
        end else begin
            clean_q <= clean;
            presses <= clean & ~clean_q & {{(num_buttons-1){1'b1}}, 1'b0};
        end
    end

endmodule

/* dac_ctrl.sv */
module dac_ctrl import board_pkg::*, audio_pkg::*; (
    input  logic        cpu_clk_g,
    input  logic        sys_rst,
    input  button_vec_t presses,
    input  duty_t       duty_cycle,
    input  logic        req,
    output logic        ack,
    input  logic        empty,
    input  duty_t       rd_data,
    output logic        rd_en,
    input  logic        period_end,
    output pwm_cmd_t    cmd,
    output led_status_t leds
);

    dac_state_t state;
    logic       mute;
    logic       underrun;

    always_ff @(posedge cpu_clk_g) begin
        if (sys_rst) begin
            state    <= DAC_REG;
            cmd      <= '0;
            mute     <= 1'b0;
            underrun <= 1'b0;
            ack      <= 1'b0;
            rd_en    <= 1'b0;
        end else begin
            ack   <= 1'b0;
            rd_en <= 1'b0;

            // Period boundary, the command below holds for the whole next period
            if (period_end) begin
                cmd.mute <= mute;
                case (state)
                    DAC_REG: begin
                        if (req) begin
                            cmd.duty <= duty_cycle;
                            ack      <= 1'b1;
                        end
                    end
                    default: begin
                        if (!empty) begin
                            cmd.duty <= rd_data;
                            rd_en    <= 1'b1;
                            state    <= DAC_STREAM;
                        end else begin
                            // Keep the old duty until samples arrive
                            state    <= DAC_STARVED;
                            underrun <= 1'b1;
                        end
                    end
                endcase
            end

            // Source toggle, wins over the boundary update of the state
            if (presses[1]) begin
                state <= (state == DAC_REG) ? DAC_STREAM : DAC_REG;
            end
            if (presses[2]) begin
                mute <= !mute;
            end
            if (presses[3]) begin
                underrun <= 1'b0;
            end
        end
    end

    assign leds.source_stream = (state != DAC_REG);
    assign leds.muted         = mute;
    assign leds.underrun      = underrun;
    assign leds.fifo_empty    = empty;

    // Only one duty source is taken per period
    a_one_source: assert property (@(posedge cpu_clk_g) disable iff (sys_rst)
        !(ack && rd_en));

endmodule

/* pwm_gen.sv */
module pwm_gen import audio_pkg::*; (
    input  logic     cpu_clk_g,
    input  logic     sys_rst,
    input  pwm_cmd_t cmd,
    output logic     period_end,
    output logic     pwm
);

    duty_t cnt;

    // Last count of the period, the controller swaps the command here
    assign period_end = (cnt == duty_t'(pwm_period - 1));

    always_ff @(posedge cpu_clk_g) begin
        if (sys_rst) begin
            cnt <= '0;
        end else begin
            // Wraps to 0 on its own after pwm_period counts
            cnt <= cnt + 1'b1;
        end
    end

    // Registered pin, so the high time lags the count by one cycle
    // At the last count no duty compares high, so the period starts low
    always_ff @(posedge cpu_clk_g) begin
        if (sys_rst) begin
            pwm <= 1'b0;
        end else begin
            pwm <= !cmd.mute && (cnt < cmd.duty);
        end
    end

    // A new period always begins at count 0
    a_period_wrap: assert property (@(posedge cpu_clk_g) disable iff (sys_rst)
        period_end |=> (cnt == '0));

endmodule

/* sample_timer.sv */
module sample_timer import board_pkg::*; (
    input  logic cpu_clk_g,
    input  logic rst,
    output logic sample_tick
);

    typedef logic [$clog2(sample_count_max)-1:0] sample_cnt_t;

    sample_cnt_t cnt;

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            cnt         <= '0;
            sample_tick <= 1'b0;
        end else begin
            // Tick once per wrap of the counter
            if (cnt == sample_cnt_t'(sample_count_max - 1)) begin
                cnt         <= '0;
                sample_tick <= 1'b1;
            end else begin
                cnt         <= cnt + 1'b1;
                sample_tick <= 1'b0;
            end
        end
    end

    // Debounce counters rely on ticks being spaced apart
    a_tick_single: assert property (@(posedge cpu_clk_g) disable iff (rst)
        sample_tick |=> !sample_tick);

endmodule

/* wave_fifo.sv */
module wave_fifo import audio_pkg::*; (
    input  logic  cpu_clk_g,
    input  logic  sys_rst,
    input  logic  wr_en,
    input  duty_t wr_data,
    output logic  full,
    input  logic  rd_en,
    output duty_t rd_data,
    output logic  empty
);

    typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;

    duty_t       mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        do_wr;
    logic        do_rd;

    assign full  = (count == fifo_count_t'(fifo_depth));
    assign empty = (count == '0);

    // Writes while full are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // First word fall through, the head entry is always on the output
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge cpu_clk_g) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The DAC controller must only pop a sample it has seen
    a_no_pop_empty: assert property (@(posedge cpu_clk_g) disable iff (sys_rst)
        !(rd_en && empty));

    a_count_range: assert property (@(posedge cpu_clk_g) disable iff (sys_rst)
        count <= fifo_count_t'(fifo_depth));

endmodule
